//--- source/lc3b_types.sv
package lc3b_types;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [2:0] lc3b_nzp;
	typedef logic [5:0] lc3b_offset6;
	typedef logic [8:0] lc3b_offset9;
	typedef logic [4:0] lc3b_imm5;

	//////////////////////////////////////////////////
	// datapath selects
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	// register file source in write back
	typedef enum logic [1:0] {
		wb_sel_alu,
		wb_sel_load,
		wb_sel_addr
	} lc3b_wb_sel;

	// supported opcodes, everything else retires as a no-op
	localparam lc3b_opcode op_br = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_lea = 4'b1110;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;

endpackage : lc3b_types

//--- source/fetch_unit.sv
module fetch_unit (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic wb_valid,
	input lc3b_types::lc3b_opcode wb_opcode,
	input lc3b_types::lc3b_nzp wb_nzp,
	input lc3b_types::lc3b_nzp cc,
	input lc3b_types::lc3b_word wb_target,
	output lc3b_types::lc3b_word pc,
	output lc3b_types::lc3b_word pc_plus2,
	output logic taken
);
	import lc3b_types::*;

	lc3b_word pc_next;

	// branch sits in write back, compare its nzp with the committed codes
	assign taken = wb_valid && (wb_opcode == op_br) && ((wb_nzp & cc) != 3'b000) && !stall;

	assign pc_plus2 = pc + 16'd2;
	assign pc_next = taken ? wb_target : pc_plus2;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 16'h0000;
		end else if (!stall) begin
			pc <= pc_next;
		end
	end

endmodule : fetch_unit

//--- source/de_register.sv
module de_register (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic fetch_resp,
	input lc3b_types::lc3b_word ir_in,
	input lc3b_types::lc3b_word pc_plus2,
	output lc3b_types::lc3b_word de_ir,
	output lc3b_types::lc3b_word de_next_pc,
	output lc3b_types::lc3b_reg de_dest,
	output lc3b_types::lc3b_reg de_src1,
	output lc3b_types::lc3b_reg de_src2,
	output logic de_valid
);

	always_ff @(posedge clk) begin
		if (!stall) begin
			de_ir <= ir_in;
			de_next_pc <= pc_plus2;
		end
	end

	// word fetched behind a taken branch comes in dead
	always_ff @(posedge clk) begin
		if (reset) begin
			de_valid <= 1'b0;
		end else if (!stall) begin
			de_valid <= fetch_resp && !flush;
		end
	end

	assign de_dest = de_ir[11:9];
	assign de_src1 = de_ir[8:6];
	assign de_src2 = de_ir[2:0];

endmodule : de_register

//--- source/control_rom.sv
module control_rom (
	input lc3b_types::lc3b_opcode opcode,
	input logic ir5,
	output lc3b_types::lc3b_alu_op alu_op,
	output logic use_imm,
	output logic addr_off9,
	output lc3b_types::lc3b_wb_sel wb_sel,
	output logic load_reg,
	output logic load_cc,
	output logic mem_read,
	output logic mem_write,
	output logic src2_is_dest
);
	import lc3b_types::*;

	always_comb begin
		alu_op = alu_pass;
		use_imm = 1'b0;
		addr_off9 = 1'b0;
		wb_sel = wb_sel_alu;
		load_reg = 1'b0;
		load_cc = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		src2_is_dest = 1'b0;

		case (opcode)
			op_add: begin
				alu_op = alu_add;
				use_imm = ir5;
				load_reg = 1'b1;
				load_cc = 1'b1;
			end
			op_and: begin
				alu_op = alu_and;
				use_imm = ir5;
				load_reg = 1'b1;
				load_cc = 1'b1;
			end
			op_not: begin
				alu_op = alu_not;
				load_reg = 1'b1;
				load_cc = 1'b1;
			end
			// lc3b lea leaves the condition codes alone
			op_lea: begin
				addr_off9 = 1'b1;
				wb_sel = wb_sel_addr;
				load_reg = 1'b1;
			end
			op_ldr: begin
				wb_sel = wb_sel_load;
				load_reg = 1'b1;
				load_cc = 1'b1;
				mem_read = 1'b1;
			end
			// store source sits in the dest field
			op_str: begin
				mem_write = 1'b1;
				src2_is_dest = 1'b1;
			end
			op_br: begin
				addr_off9 = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule : control_rom

//--- source/regfile.sv
module regfile (
	input clk,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word data [8];

	always_ff @(posedge clk) begin
		if (load) begin
			data[dest] <= in;
		end
	end

	// write-through, decode sees the value committing this cycle
	assign reg_a = (load && (dest == src_a)) ? in : data[src_a];
	assign reg_b = (load && (dest == src_b)) ? in : data[src_b];

endmodule : regfile

//--- source/ex_register.sv
module ex_register (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input lc3b_types::lc3b_word de_ir, de_next_pc, de_sr1, de_sr2,
	input lc3b_types::lc3b_reg de_dest,
	input logic de_valid,
	input lc3b_types::lc3b_alu_op alu_op,
	input lc3b_types::lc3b_wb_sel wb_sel,
	input logic use_imm, addr_off9, load_reg, load_cc, mem_read, mem_write,
	output lc3b_types::lc3b_word ex_ir, ex_next_pc, ex_sr1, ex_sr2,
	output lc3b_types::lc3b_reg ex_dest,
	output logic ex_valid,
	output lc3b_types::lc3b_alu_op ex_alu_op,
	output lc3b_types::lc3b_wb_sel ex_wb_sel,
	output logic ex_use_imm, ex_addr_off9, ex_load_reg, ex_load_cc,
	output logic ex_mem_read, ex_mem_write
);

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_ir <= de_ir;
			ex_next_pc <= de_next_pc;
			ex_sr1 <= de_sr1;
			ex_sr2 <= de_sr2;
			ex_dest <= de_dest;
			ex_alu_op <= alu_op;
			ex_wb_sel <= wb_sel;
			ex_use_imm <= use_imm;
			ex_addr_off9 <= addr_off9;
			ex_load_reg <= load_reg;
			ex_load_cc <= load_cc;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (!stall) begin
			ex_valid <= de_valid && !flush;
		end
	end

endmodule : ex_register

//--- source/ex_logic.sv
module ex_logic (
	input lc3b_types::lc3b_alu_op alu_op,
	input logic use_imm,
	input logic addr_off9,
	input lc3b_types::lc3b_word ex_ir,
	input lc3b_types::lc3b_word ex_next_pc,
	input lc3b_types::lc3b_word ex_sr1,
	input lc3b_types::lc3b_word ex_sr2,
	output lc3b_types::lc3b_word ex_alu_out,
	output lc3b_types::lc3b_word ex_address
);
	import lc3b_types::*;

	lc3b_imm5 imm5;
	lc3b_offset6 offset6;
	lc3b_offset9 offset9;
	lc3b_word operand_b;

	assign imm5 = ex_ir[4:0];
	assign offset6 = ex_ir[5:0];
	assign offset9 = ex_ir[8:0];

	assign operand_b = use_imm ? {{11{imm5[4]}}, imm5} : ex_sr2;

	always_comb begin
		case (alu_op)
			alu_add: ex_alu_out = ex_sr1 + operand_b;
			alu_and: ex_alu_out = ex_sr1 & operand_b;
			alu_not: ex_alu_out = ~ex_sr1;
			default: ex_alu_out = operand_b;
		endcase
	end

	// offsets count words, one extra low zero makes them byte offsets
	assign ex_address = addr_off9 ? ex_next_pc + {{6{offset9[8]}}, offset9, 1'b0}
		: ex_sr1 + {{9{offset6[5]}}, offset6, 1'b0};

endmodule : ex_logic

//--- source/mem_register.sv
module mem_register (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input lc3b_types::lc3b_word ex_address, ex_alu_out, ex_store_data, ex_ir,
	input lc3b_types::lc3b_reg ex_dest,
	input lc3b_types::lc3b_wb_sel ex_wb_sel,
	input logic ex_load_reg, ex_load_cc, ex_mem_read, ex_mem_write,
	input logic ex_valid,
	output lc3b_types::lc3b_word mem_address, mem_alu_out, mem_store_data, mem_ir,
	output lc3b_types::lc3b_reg mem_dest,
	output lc3b_types::lc3b_wb_sel mem_wb_sel,
	output logic mem_load_reg, mem_load_cc, mem_mem_read, mem_mem_write,
	output logic mem_valid
);

	// held through a stall so the data port sees a stable request
	always_ff @(posedge clk) begin
		if (!stall) begin
			mem_address <= ex_address;
			mem_alu_out <= ex_alu_out;
			mem_store_data <= ex_store_data;
			mem_ir <= ex_ir;
			mem_dest <= ex_dest;
			mem_wb_sel <= ex_wb_sel;
			mem_load_reg <= ex_load_reg;
			mem_load_cc <= ex_load_cc;
			mem_mem_read <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid <= 1'b0;
		end else if (!stall) begin
			mem_valid <= ex_valid && !flush;
		end
	end

endmodule : mem_register

//--- source/wb_stage.sv
module wb_stage (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_types::lc3b_word mem_address, mem_alu_out, mem_ir,
	input lc3b_types::lc3b_reg mem_dest,
	input lc3b_types::lc3b_wb_sel mem_wb_sel,
	input logic mem_load_reg, mem_load_cc, mem_valid,
	input lc3b_types::lc3b_word mem_rdata,
	output logic wb_valid,
	output lc3b_types::lc3b_opcode wb_opcode,
	output lc3b_types::lc3b_nzp wb_nzp,
	output lc3b_types::lc3b_word wb_target,
	output lc3b_types::lc3b_nzp cc,
	output logic reg_load,
	output lc3b_types::lc3b_reg reg_dest,
	output lc3b_types::lc3b_word reg_data
);
	import lc3b_types::*;

	lc3b_word wb_address, wb_alu_out, wb_rdata, wb_ir;
	lc3b_wb_sel wb_sel;
	logic wb_load_reg, wb_load_cc;
	logic commit;
	lc3b_nzp gen_cc;

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_address <= mem_address;
			wb_alu_out <= mem_alu_out;
			wb_rdata <= mem_rdata;
			wb_ir <= mem_ir;
			reg_dest <= mem_dest;
			wb_sel <= mem_wb_sel;
			wb_load_reg <= mem_load_reg;
			wb_load_cc <= mem_load_cc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			cc <= 3'b010;
		end else begin
			if (commit && wb_load_cc) begin
				cc <= gen_cc;
			end
			if (!stall) begin
				wb_valid <= mem_valid;
			end
		end
	end

	// nothing retires while either port is waiting
	assign commit = wb_valid && !stall;
	assign reg_load = commit && wb_load_reg;

	always_comb begin
		case (wb_sel)
			wb_sel_load: reg_data = wb_rdata;
			wb_sel_addr: reg_data = wb_address;
			default: reg_data = wb_alu_out;
		endcase
	end

	assign gen_cc = reg_data[15] ? 3'b100 : ((reg_data == 16'h0000) ? 3'b010 : 3'b001);

	assign wb_opcode = wb_ir[15:12];
	assign wb_nzp = wb_ir[11:9];
	assign wb_target = wb_address;

endmodule : wb_stage

//--- source/datapath.sv
module datapath (
	input logic clk,
	input logic reset,
	input logic mem_resp_a,
	input lc3b_types::lc3b_word mem_rdata_a,
	input logic mem_resp_b,
	input lc3b_types::lc3b_word mem_rdata_b,
	output logic mem_read_a,
	output logic mem_write_a,
	output logic [1:0] mem_wmask_a,
	output lc3b_types::lc3b_word mem_address_a,
	output lc3b_types::lc3b_word mem_wdata_a,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output lc3b_types::lc3b_word mem_address_b,
	output lc3b_types::lc3b_word mem_wdata_b
);
	import lc3b_types::*;

	logic stall, taken, squash, mem_live;
	lc3b_word pc, pc_plus2;
	// decode
	lc3b_word de_ir, de_next_pc, de_sr1, de_sr2;
	lc3b_reg de_dest, de_src1, de_src2, src_b;
	logic de_valid;
	lc3b_alu_op alu_op;
	lc3b_wb_sel wb_sel;
	logic use_imm, addr_off9, load_reg, load_cc, mem_read, mem_write, src2_is_dest;
	// execute
	lc3b_word ex_ir, ex_next_pc, ex_sr1, ex_sr2, ex_alu_out, ex_address;
	lc3b_reg ex_dest;
	lc3b_alu_op ex_alu_op;
	lc3b_wb_sel ex_wb_sel;
	logic ex_valid, ex_use_imm, ex_addr_off9, ex_load_reg, ex_load_cc;
	logic ex_mem_read, ex_mem_write;
	// memory
	lc3b_word mem_address, mem_alu_out, mem_store_data, mem_ir;
	lc3b_reg mem_dest;
	lc3b_wb_sel mem_wb_sel;
	logic mem_valid, mem_load_reg, mem_load_cc, mem_mem_read, mem_mem_write;
	// write back
	lc3b_opcode wb_opcode;
	lc3b_nzp wb_nzp, cc;
	lc3b_word wb_target, reg_data;
	lc3b_reg reg_dest;
	logic wb_valid, reg_load;

	//////////////////////////////////////////////////
	// memory ports and pipeline control
	//////////////////////////////////////////////////

	// instruction behind a taken branch gets no data port access
	assign squash = wb_valid && (wb_opcode == op_br) && ((wb_nzp & cc) != 3'b000);
	assign mem_live = mem_valid && !squash;

	assign stall = (mem_read_a && !mem_resp_a) || ((mem_read_b || mem_write_b) && !mem_resp_b);

	// instruction port reads every cycle
	assign mem_read_a = !reset;
	assign mem_write_a = 1'b0;
	assign mem_wmask_a = 2'b11;
	assign mem_address_a = pc;
	assign mem_wdata_a = 16'h0000;

	assign mem_read_b = mem_live && mem_mem_read;
	assign mem_write_b = mem_live && mem_mem_write;
	assign mem_wmask_b = 2'b11;
	assign mem_address_b = mem_address;
	assign mem_wdata_b = mem_store_data;

	//////////////////////////////////////////////////
	// fetch and decode
	//////////////////////////////////////////////////

	fetch_unit u_fetch_unit (.*);

	de_register u_de_register (
		.*,
		.flush(taken),
		.fetch_resp(mem_resp_a),
		.ir_in(mem_rdata_a)
	);

	control_rom u_control_rom (
		.*,
		.opcode(de_ir[15:12]),
		.ir5(de_ir[5])
	);

	assign src_b = src2_is_dest ? de_dest : de_src2;

	regfile u_regfile (
		.clk,
		.load(reg_load),
		.dest(reg_dest),
		.in(reg_data),
		.src_a(de_src1),
		.src_b(src_b),
		.reg_a(de_sr1),
		.reg_b(de_sr2)
	);

	//////////////////////////////////////////////////
	// execute, memory, write back
	//////////////////////////////////////////////////

	ex_register u_ex_register (
		.*,
		.flush(taken)
	);

	ex_logic u_ex_logic (
		.*,
		.alu_op(ex_alu_op),
		.use_imm(ex_use_imm),
		.addr_off9(ex_addr_off9)
	);

	mem_register u_mem_register (
		.*,
		.flush(taken),
		.ex_store_data(ex_sr2)
	);

	wb_stage u_wb_stage (
		.*,
		.mem_valid(mem_live),
		.mem_rdata(mem_rdata_b)
	);

endmodule : datapath

//--- tb/datapath_tb.sv
module datapath_tb;

	localparam int num_entries = 6;
	localparam int num_programs = 3;
	localparam int prog_len = 20;
	// worst case three cycles per word, plus reset and drain per entry
	localparam int cycle_limit = num_entries * (prog_len * 3 + 16 + 12 + 4) + 100;

	//////////////////////////////////////////////////
	// program table
	//////////////////////////////////////////////////

	// 0: alu forms, 1: ldr/str/lea, 2: branches with n, z and p
	localparam logic [15:0] programs [num_programs][prog_len] = '{
		'{16'h5020, 16'h5260, 16'h54A0, 16'h163D, 16'h126C, 16'h14AA, 16'h7600,
			16'h1A43, 16'h5842, 16'h9CBF, 16'h7A01, 16'h7802, 16'h7C03, 16'h5EF0,
			16'h0000, 16'h0000, 16'h7E3F, 16'h0000, 16'h0000, 16'h0000},
		'{16'h5020, 16'h0000, 16'h0000, 16'h1028, 16'h0000, 16'h0000, 16'h6204,
			16'hE405, 16'h0000, 16'h723E, 16'h7401, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h5020, 16'h5260, 16'h0000, 16'h123F, 16'h0802, 16'h7200, 16'h7200,
			16'h0401, 16'h7201, 16'h1420, 16'h0402, 16'h7202, 16'h7202, 16'h0201,
			16'h1625, 16'h0A02, 16'h7203, 16'h7203, 16'h7604, 16'h0000}
	};
	localparam logic [15:0] exp_addr [num_programs][5] = '{
		'{16'h0000, 16'h0002, 16'h0004, 16'h0006, 16'hFFFE},
		'{16'h0004, 16'h000A, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0002, 16'h0008, 16'h0000, 16'h0000, 16'h0000}
	};
	localparam logic [15:0] exp_data [num_programs][5] = '{
		'{16'hFFFD, 16'h0009, 16'h0008, 16'hFFF5, 16'hFFF0},
		'{16'hBEEF, 16'h001A, 16'h0000, 16'h0000, 16'h0000},
		'{16'hFFFF, 16'h0005, 16'h0000, 16'h0000, 16'h0000}
	};
	localparam int exp_count [num_programs] = '{5, 2, 2};
	localparam int preset_index [num_programs] = '{40, 8, 40};
	localparam logic [15:0] preset_value [num_programs] = '{16'h1234, 16'hBEEF, 16'h1234};

	logic clk, reset;
	logic mem_resp_a, mem_resp_b;
	logic [15:0] mem_rdata_a, mem_rdata_b;
	logic mem_read_a, mem_write_a, mem_read_b, mem_write_b;
	logic [1:0] mem_wmask_a, mem_wmask_b;
	logic [15:0] mem_address_a, mem_wdata_a, mem_address_b, mem_wdata_b;

	logic [15:0] imem [64];
	logic [15:0] dmem [64];
	logic [31:0] rng;
	int cur_prog, store_count, cycles, new_lat;
	int lat_a, lat_b, wait_a, wait_b;
	logic random_lat, pending_b;
	logic [15:0] held_addr, held_data;

	datapath u_dut (.*);

	// read data follows the address and resp carries the latency
	assign mem_rdata_a = imem[mem_address_a[6:1]];
	assign mem_rdata_b = dmem[mem_address_b[6:1]];

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int draw_latency();
		rng = lcg_next(rng);
		return random_lat ? int'((rng >> 16) % 3) : 0;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	//////////////////////////////////////////////////
	// memory models
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 64; i++) begin
				imem[i] <= (i < prog_len) ? programs[cur_prog][i] : 16'h0000;
				dmem[i] <= (i == preset_index[cur_prog]) ? preset_value[cur_prog]
					: (16'h3c00 | 16'(i));
			end
			store_count <= 0;
		end
		// instruction port reads whenever out of reset and never writes
		check_value({15'd0, mem_read_a}, {15'd0, !reset}, "instruction read");
		check_value({15'd0, mem_write_a}, 16'h0000, "instruction write");
		if (mem_read_a && !mem_resp_a) begin
			wait_a <= wait_a + 1;
			mem_resp_a <= (wait_a + 1 >= lat_a);
		end else begin
			new_lat = draw_latency();
			lat_a <= new_lat;
			wait_a <= 0;
			mem_resp_a <= (new_lat == 0);
		end
		// a waiting request must not move
		if (pending_b && (mem_read_b || mem_write_b)) begin
			check_value(mem_address_b, held_addr, "held data address");
			if (mem_write_b)
				check_value(mem_wdata_b, held_data, "held store data");
		end
		pending_b <= (mem_read_b || mem_write_b) && !mem_resp_b;
		held_addr <= mem_address_b;
		held_data <= mem_wdata_b;
		if ((mem_read_b || mem_write_b) && !mem_resp_b) begin
			wait_b <= wait_b + 1;
			mem_resp_b <= (wait_b + 1 >= lat_b);
		end else begin
			new_lat = draw_latency();
			lat_b <= new_lat;
			wait_b <= 0;
			mem_resp_b <= (new_lat == 0);
		end
		if (mem_write_b && mem_resp_b && !reset) begin
			dmem[mem_address_b[6:1]] <= mem_wdata_b;
			// a store answered while the fetch still waits is counted when it moves on
			if (!(mem_read_a && !mem_resp_a)) begin
				if (store_count >= exp_count[cur_prog])
					abort_run($sformatf("unexpected store to %h at %0t", mem_address_b, $time));
				check_value(mem_address_b, exp_addr[cur_prog][store_count], "store address");
				check_value(mem_wdata_b, exp_data[cur_prog][store_count], "store data");
				check_value({14'd0, mem_wmask_b}, 16'h0003, "store byte mask");
				store_count <= store_count + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run("timeout, the expected stores never all arrived");
	end

	//////////////////////////////////////////////////
	// entry loop
	//////////////////////////////////////////////////

	task automatic run_entry(input int e);
		@(posedge clk);
		cur_prog <= e % num_programs;
		random_lat <= (e >= num_programs);
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		#1;
		check_value(mem_address_a, 16'h0000, "fetch address after reset");
		check_value({15'd0, mem_read_b}, 16'h0000, "mem_read_b after reset");
		check_value({15'd0, mem_write_b}, 16'h0000, "mem_write_b after reset");
		while (store_count < exp_count[cur_prog])
			@(posedge clk);
		// a late store during the drain is an error
		repeat (12) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mem_resp_a = 1'b0;
		mem_resp_b = 1'b0;
		rng = 32'h4624;
		cur_prog = 0;
		random_lat = 1'b0;
		store_count = 0;
		cycles = 0;
		pending_b = 1'b0;
		wait_a = 0;
		wait_b = 0;
		lat_a = 0;
		lat_b = 0;
		for (int e = 0; e < num_entries; e++)
			run_entry(e);
		$display("All tests passed");
		$finish;
	end

endmodule : datapath_tb

//--- project.f
source/lc3b_types.sv
source/fetch_unit.sv
source/de_register.sv
source/control_rom.sv
source/regfile.sv
source/ex_register.sv
source/ex_logic.sv
source/mem_register.sv
source/wb_stage.sv
source/datapath.sv
tb/datapath_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module datapath_tb -f project.f -o sim

run: compile
	./obj_dir/sim | tee run.log
	@if grep -q "Some tests failed" run.log; then exit 1; fi
	@grep -q "All tests passed" run.log

clean:
	rm -rf obj_dir run.log
